// File: include/spi_target_params.svh
// SPI target sizing: byte width, register bank depth, pin synchronizer depth and idle byte
`ifndef SPI_TARGET_PARAMS_SVH
`define SPI_TARGET_PARAMS_SVH

// Width of one SPI byte and of each register
`define SPI_DATA_W 8

// Register bank geometry
`define REG_COUNT  16
`define REG_ADDR_W 4

// Flops per SPI pin before edge detection
`define SPI_SYNC_STAGES 2

// Returned on MISO during the command byte and in write frames
`define SPI_IDLE_BYTE 8'hA5

`endif

// File: verilog/spi_target_pkg.sv
// SPI target types: command byte layout and the register bank request word
`default_nettype none

`include "spi_target_params.svh"

package spi_target_pkg;

    // First byte of every frame
    typedef struct packed {
        logic                   read;   // 1 = read frame, 0 = write frame
        logic [2:0]             rsvd;   // Ignored
        logic [`REG_ADDR_W-1:0] addr;   // Start address of the burst
    } spi_cmd_t;

    // Carried alongside req, held stable until ack
    typedef struct packed {
        logic                   write;  // 1 = store wdata, 0 = fetch
        logic [`REG_ADDR_W-1:0] addr;   // Target register
        logic [`SPI_DATA_W-1:0] wdata;  // Only meaningful on writes
    } reg_req_t;

endpackage

`default_nettype wire

// File: verilog/spi_byte_shifter.sv
// SPI mode 0 byte shifter: pin synchronizers, SCLK edge detection, RX and TX shift registers
`timescale 1ns/1ps
`default_nettype none

`include "spi_target_params.svh"

module spi_byte_shifter (
    input  logic                   cs,
    input  logic                   sck,
    input  logic                   spi_sclk_i,
    input  logic                   spi_cs_ni,
    input  logic                   spi_mosi_i,
    input  logic                   last_bit_i,
    input  logic [`SPI_DATA_W-1:0] tx_byte_i,
    output logic                   spi_miso_o,
    output logic                   sclk_rise_o,
    output logic                   sclk_fall_o,
    output logic                   frame_active_o,
    output logic                   byte_done_o,
    output logic [`SPI_DATA_W-1:0] rx_byte_o
);
    localparam int SYNC_LAST = `SPI_SYNC_STAGES - 1;
    localparam int DATA_MSB  = `SPI_DATA_W - 1;

    logic [`SPI_SYNC_STAGES-1:0] sclk_sync;
    logic [`SPI_SYNC_STAGES-1:0] cs_n_sync;
    logic [`SPI_SYNC_STAGES-1:0] mosi_sync;
    logic                        sclk_q;
    logic                        frame_active_q;
    logic                        frame_start;
    logic                        load_pending;
    logic [`SPI_DATA_W-1:0]      rx_shift;
    logic [`SPI_DATA_W-1:0]      tx_shift;

    // Two flops per pin, then one more on SCLK to find its edges
    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            sclk_sync      <= '0;
            cs_n_sync      <= '1;           // Deselected
            mosi_sync      <= '0;
            sclk_q         <= 1'b0;
            frame_active_q <= 1'b0;
        end else begin
            sclk_sync      <= {sclk_sync[SYNC_LAST-1:0], spi_sclk_i};
            cs_n_sync      <= {cs_n_sync[SYNC_LAST-1:0], spi_cs_ni};
            mosi_sync      <= {mosi_sync[SYNC_LAST-1:0], spi_mosi_i};
            sclk_q         <= sclk_sync[SYNC_LAST];
            frame_active_q <= frame_active_o;
        end
    end

    assign sclk_rise_o    = sclk_sync[SYNC_LAST] && !sclk_q;
    assign sclk_fall_o    = !sclk_sync[SYNC_LAST] && sclk_q;
    assign frame_active_o = !cs_n_sync[SYNC_LAST];
    assign frame_start    = frame_active_o && !frame_active_q;

    // Receive side, MOSI sampled on rising SCLK
    always_ff @(posedge cs) begin
        if (sclk_rise_o && frame_active_o) begin
            rx_shift <= {rx_shift[DATA_MSB-1:0], mosi_sync[SYNC_LAST]};
            if (last_bit_i) begin
                rx_byte_o <= {rx_shift[DATA_MSB-1:0], mosi_sync[SYNC_LAST]};
            end
        end
    end

    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            byte_done_o <= 1'b0;
        end else begin
            byte_done_o <= sclk_rise_o && frame_active_o && last_bit_i;
        end
    end

    // Transmit side, MSB first, advanced on falling SCLK
    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            tx_shift     <= `SPI_IDLE_BYTE;
            load_pending <= 1'b0;
        end else if (frame_start) begin
            tx_shift     <= tx_byte_i;      // MSB on the line before the first rise
            load_pending <= 1'b0;
        end else if (frame_active_o) begin
            if (byte_done_o) begin
                load_pending <= 1'b1;       // Next fall starts a new byte
            end else if (sclk_fall_o) begin
                if (load_pending) begin
                    tx_shift     <= tx_byte_i;
                    load_pending <= 1'b0;
                end else begin
                    tx_shift <= {tx_shift[DATA_MSB-1:0], 1'b0};
                end
            end
        end else begin
            load_pending <= 1'b0;
        end
    end

    assign spi_miso_o = tx_shift[DATA_MSB];

endmodule

`default_nettype wire

// File: verilog/spi_frame_counter.sv
// SPI frame counter: bit position within the byte and byte index within the frame
`timescale 1ns/1ps
`default_nettype none

`include "spi_target_params.svh"

module spi_frame_counter (
    input  logic       cs,
    input  logic       sck,
    input  logic       sclk_rise_i,
    input  logic       frame_active_i,
    output logic       last_bit_o,
    output logic [1:0] byte_index_o
);
    localparam int BIT_W = $clog2(`SPI_DATA_W);

    logic [BIT_W-1:0] bit_cnt;

    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            bit_cnt      <= '0;
            byte_index_o <= '0;
        end else if (!frame_active_i) begin
            bit_cnt      <= '0;             // Chip select high restarts the byte
            byte_index_o <= '0;
        end else if (sclk_rise_i) begin
            bit_cnt <= bit_cnt + 1'b1;      // Wraps to 0 after the last bit
            if (last_bit_o && (byte_index_o != 2'd3)) begin
                byte_index_o <= byte_index_o + 1'b1;
            end
        end
    end

    assign last_bit_o = (bit_cnt == BIT_W'(`SPI_DATA_W - 1));

endmodule

`default_nettype wire

// File: verilog/spi_cmd_fsm.sv
// SPI command FSM: decodes the command byte, steps the address and drives the register handshake
`timescale 1ns/1ps
`default_nettype none

`include "spi_target_params.svh"

module spi_cmd_fsm (
    input  logic                     cs,
    input  logic                     sck,
    input  logic                     byte_done_i,
    input  logic [`SPI_DATA_W-1:0]   rx_byte_i,
    input  logic [1:0]               byte_index_i,
    input  logic                     frame_active_i,
    output logic [`SPI_DATA_W-1:0]   tx_byte_o,
    output logic                     req_o,
    output spi_target_pkg::reg_req_t reg_req_o,
    input  logic                     ack_i,
    input  logic [`SPI_DATA_W-1:0]   rdata_i
);
    import spi_target_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ,
        WRITE_WAIT,
        DATA
    } state_t;

    state_t                 state;
    logic                   read_mode;
    logic [`REG_ADDR_W-1:0] addr_q;
    spi_cmd_t               cmd;
    logic                   cmd_done;
    logic                   data_done;
    logic                   start_req;
    reg_req_t               next_req;

    assign cmd = spi_cmd_t'(rx_byte_i);

    // The index has already advanced when byte_done arrives, so 1 marks the command byte
    assign cmd_done  = byte_done_i && (byte_index_i == 2'd1);
    assign data_done = byte_done_i && (byte_index_i != 2'd1);

    always_comb begin
        start_req = 1'b0;
        next_req  = reg_req_o;
        if (frame_active_i) begin
            if (state == CMD && cmd_done && cmd.read) begin
                start_req      = 1'b1;      // Prefetch for the first data byte
                next_req.write = 1'b0;
                next_req.addr  = cmd.addr;
                next_req.wdata = '0;
            end else if (state == DATA && data_done) begin
                start_req      = 1'b1;
                next_req.write = !read_mode;
                next_req.addr  = read_mode ? addr_q + 1'b1 : addr_q;
                next_req.wdata = rx_byte_i;
            end
        end
    end

    // Request word only changes when a new request opens
    always_ff @(posedge cs) begin
        if (start_req) begin
            reg_req_o <= next_req;
        end
    end

    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            state     <= IDLE;
            read_mode <= 1'b0;
            addr_q    <= '0;
            req_o     <= 1'b0;
            tx_byte_o <= `SPI_IDLE_BYTE;
        end else begin
            case (state)
                IDLE: begin
                    tx_byte_o <= `SPI_IDLE_BYTE;
                    if (frame_active_i) begin
                        state <= CMD;
                    end
                end
                CMD: begin
                    if (!frame_active_i) begin
                        state <= IDLE;
                    end else if (cmd_done) begin
                        read_mode <= cmd.read;
                        addr_q    <= cmd.addr;
                        req_o     <= cmd.read;
                        state     <= cmd.read ? READ_REQ : DATA;
                    end
                end
                DATA: begin
                    if (!frame_active_i) begin
                        state <= IDLE;
                    end else if (start_req) begin
                        req_o  <= 1'b1;
                        addr_q <= next_req.addr;
                        state  <= read_mode ? READ_REQ : WRITE_REQ;
                    end
                end
                READ_REQ: begin
                    if (ack_i) begin
                        req_o     <= 1'b0;
                        tx_byte_o <= rdata_i;   // Shifted out from the next fall
                        state     <= READ_WAIT;
                    end
                end
                WRITE_REQ: begin
                    if (ack_i) begin
                        req_o  <= 1'b0;
                        addr_q <= addr_q + 1'b1;    // Wraps modulo 16
                        state  <= WRITE_WAIT;
                    end
                end
                READ_WAIT, WRITE_WAIT: begin
                    if (!ack_i) begin
                        state <= frame_active_i ? DATA : IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_bank.sv
// Register bank: sixteen byte registers served over a four-phase req/ack handshake
`timescale 1ns/1ps
`default_nettype none

`include "spi_target_params.svh"

module reg_bank (
    input  logic                     cs,
    input  logic                     sck,
    input  logic                     req_i,
    input  spi_target_pkg::reg_req_t reg_req_i,
    output logic                     ack_o,
    output logic [`SPI_DATA_W-1:0]   rdata_o
);
    logic [`SPI_DATA_W-1:0] regs [`REG_COUNT];
    logic                   access;

    // Acts once per request, on the cycle before ack rises
    assign access = req_i && !ack_o;

    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            ack_o <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            ack_o <= req_i;                 // Rises after req, falls after req drops
            if (access && reg_req_i.write) begin
                regs[reg_req_i.addr] <= reg_req_i.wdata;
            end
        end
    end

    // Read data is presented together with ack
    always_ff @(posedge cs) begin
        if (access) begin
            rdata_o <= regs[reg_req_i.addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/spi_target.sv
// SPI target top: byte shifter, frame counter, command FSM and register bank
`timescale 1ns/1ps
`default_nettype none

`include "spi_target_params.svh"

module spi_target (
    input  logic cs,
    input  logic sck,
    input  logic spi_sclk_i,
    input  logic spi_cs_ni,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);
    import spi_target_pkg::*;

    logic                   sclk_rise;
    logic                   frame_active;
    logic                   last_bit;
    logic [1:0]             byte_index;
    logic                   byte_done;
    logic [`SPI_DATA_W-1:0] rx_byte;
    logic [`SPI_DATA_W-1:0] tx_byte;
    logic                   req;
    logic                   ack;
    reg_req_t               reg_req;
    logic [`SPI_DATA_W-1:0] rdata;

    spi_byte_shifter u_shifter (
        .cs             (cs),
        .sck            (sck),
        .spi_sclk_i     (spi_sclk_i),
        .spi_cs_ni      (spi_cs_ni),
        .spi_mosi_i     (spi_mosi_i),
        .last_bit_i     (last_bit),
        .tx_byte_i      (tx_byte),
        .spi_miso_o     (spi_miso_o),
        .sclk_rise_o    (sclk_rise),
        .sclk_fall_o    (),         // Only used inside the shifter
        .frame_active_o (frame_active),
        .byte_done_o    (byte_done),
        .rx_byte_o      (rx_byte)
    );

    spi_frame_counter u_frame_cnt (
        .cs             (cs),
        .sck            (sck),
        .sclk_rise_i    (sclk_rise),
        .frame_active_i (frame_active),
        .last_bit_o     (last_bit),
        .byte_index_o   (byte_index)
    );

    spi_cmd_fsm u_cmd_fsm (
        .cs             (cs),
        .sck            (sck),
        .byte_done_i    (byte_done),
        .rx_byte_i      (rx_byte),
        .byte_index_i   (byte_index),
        .frame_active_i (frame_active),
        .tx_byte_o      (tx_byte),
        .req_o          (req),
        .reg_req_o      (reg_req),
        .ack_i          (ack),
        .rdata_i        (rdata)
    );

    reg_bank u_reg_bank (
        .cs        (cs),
        .sck       (sck),
        .req_i     (req),
        .reg_req_i (reg_req),
        .ack_o     (ack),
        .rdata_o   (rdata)
    );

endmodule

`default_nettype wire

// File: testbench/spi_target_assertions.sv
// SPI target assertions: four-phase req/ack rules and reset state between the FSM and the bank
`timescale 1ns/1ps
`default_nettype none

module spi_target_assertions (
    input logic                     cs,
    input logic                     sck,
    input logic                     req_i,
    input logic                     ack_i,
    input spi_target_pkg::reg_req_t reg_req_i
);

    // Request may not be withdrawn early
    req_held_until_ack: assert property (
        @(posedge cs) disable iff (!sck)
        (req_i && !ack_i) |=> req_i
    ) else $error("req dropped before ack was seen");

    ack_only_with_req: assert property (
        @(posedge cs) disable iff (!sck)
        $rose(ack_i) |-> req_i
    ) else $error("ack rose while req was low");

    // Address, direction and write data frozen for the whole request
    req_word_stable: assert property (
        @(posedge cs) disable iff (!sck)
        req_i |=> (!req_i || $stable(reg_req_i))
    ) else $error("request word changed while req was high");

    idle_after_reset: assert property (
        @(posedge cs)
        $rose(sck) |-> (!req_i && !ack_i)
    ) else $error("req or ack high in the first cycle after reset");

endmodule

`default_nettype wire

// File: testbench/spi_target_tb.sv
// SPI target testbench: mode 0 controller model, reference register model, watchdog and verdict
`timescale 1ns/1ps
`default_nettype none

`include "spi_target_params.svh"

module spi_target_tb;
    localparam int          CLK_PERIOD      = 40;
    localparam int          RESET_CYCLES    = 8;
    localparam int          HALF_SCLK       = 8;    // cs cycles per SCLK half period
    localparam int          NUM_FRAMES      = 11;
    localparam int          MAX_FRAME_SCLKS = 17 * `SPI_DATA_W + 2;
    localparam int          TIMEOUT_NS      = 2 * NUM_FRAMES * MAX_FRAME_SCLKS * 16 * CLK_PERIOD;
    localparam logic [31:0] RAND_SEED       = 32'h292c;

    logic                   cs;
    logic                   sck;
    logic                   spi_sclk_i;
    logic                   spi_cs_ni;
    logic                   spi_mosi_i;
    logic                   spi_miso_o;
    logic [`SPI_DATA_W-1:0] ref_regs [`REG_COUNT];  // Expected register contents

    spi_target dut (
        .cs         (cs),
        .sck        (sck),
        .spi_sclk_i (spi_sclk_i),
        .spi_cs_ni  (spi_cs_ni),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o)
    );

    // Handshake and reset rules on the FSM side of the register bank
    bind spi_cmd_fsm spi_target_assertions u_fsm_assert (
        .cs        (cs),
        .sck       (sck),
        .req_i     (req_o),
        .ack_i     (ack_i),
        .reg_req_i (reg_req_o)
    );

    initial cs = 1'b0;
    always #(CLK_PERIOD / 2) cs = ~cs;

    task automatic check_byte(input string name, input logic [`SPI_DATA_W-1:0] exp_val,
                              input logic [`SPI_DATA_W-1:0] act_val);
        assert (act_val === exp_val) else begin
            $display("CHECK FAILED %s expected %02h actual %02h", name, exp_val, act_val);
            $display("Test failed");
            $fatal(1, "Read data mismatch");
        end
    endtask

    // Mode 0 bit loop, MOSI changes with the falling SCLK
    task automatic shift_bits(input logic [`SPI_DATA_W-1:0] tx, input int nbits,
                              output logic [`SPI_DATA_W-1:0] rx);
        rx = '0;
        for (int i = 0; i < nbits; i++) begin
            spi_mosi_i = tx[`SPI_DATA_W-1-i];
            repeat (HALF_SCLK) @(negedge cs);
            rx = {rx[`SPI_DATA_W-2:0], spi_miso_o};   // Sampled just before the rise
            spi_sclk_i = 1'b1;
            repeat (HALF_SCLK) @(negedge cs);
            spi_sclk_i = 1'b0;
        end
    endtask

    task automatic begin_frame();
        @(negedge cs);
        spi_cs_ni = 1'b0;
    endtask

    task automatic end_frame();
        repeat (HALF_SCLK) @(negedge cs);
        spi_cs_ni  = 1'b1;
        spi_mosi_i = 1'b0;
        repeat (2 * HALF_SCLK) @(negedge cs);   // One SCLK period deselected
    endtask

    task automatic write_random(input logic [`REG_ADDR_W-1:0] addr, input int count);
        logic [`REG_ADDR_W-1:0] a;
        logic [31:0]            rnd;
        logic [`SPI_DATA_W-1:0] rx;
        a = addr;
        begin_frame();
        shift_bits({1'b0, 3'b000, addr}, `SPI_DATA_W, rx);
        for (int k = 0; k < count; k++) begin
            rnd         = $urandom;
            ref_regs[a] = rnd[`SPI_DATA_W-1:0];
            shift_bits(rnd[`SPI_DATA_W-1:0], `SPI_DATA_W, rx);
            a = a + 1'b1;                       // Wraps modulo 16
        end
        end_frame();
    endtask

    task automatic read_check(input string name, input logic [`REG_ADDR_W-1:0] addr,
                              input int count);
        logic [`REG_ADDR_W-1:0] a;
        logic [`SPI_DATA_W-1:0] rx;
        a = addr;
        begin_frame();
        shift_bits({1'b1, 3'b000, addr}, `SPI_DATA_W, rx);
        check_byte(name, `SPI_IDLE_BYTE, rx);   // Nothing fetched yet during the command
        for (int k = 0; k < count; k++) begin
            shift_bits('0, `SPI_DATA_W, rx);
            check_byte(name, ref_regs[a], rx);
            a = a + 1'b1;
        end
        end_frame();
    endtask

    initial begin
        logic [31:0]            rnd;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`SPI_DATA_W-1:0] rx;
        sck        = 1'b0;
        spi_sclk_i = 1'b0;
        spi_cs_ni  = 1'b1;
        spi_mosi_i = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        rnd = $urandom(RAND_SEED);
        repeat (RESET_CYCLES) @(negedge cs);
        sck = 1'b1;
        repeat (4) @(negedge cs);

        read_check("reset_read", 4'h0, 4);

        rnd  = $urandom;
        addr = rnd[`REG_ADDR_W-1:0];
        write_random(addr, 1);
        read_check("single_write_read", addr, 1);

        write_random(4'hE, 16);
        read_check("burst_wrap", 4'hE, 16);

        // Write frame dropped five bits into its data byte
        rnd  = $urandom;
        addr = rnd[`REG_ADDR_W-1:0];
        begin_frame();
        shift_bits({1'b0, 3'b000, addr}, `SPI_DATA_W, rx);
        shift_bits(rnd[15:8], 5, rx);
        end_frame();
        read_check("abandoned_frame", 4'h0, 16);

        for (int f = 0; f < 4; f++) begin
            rnd  = $urandom;
            addr = rnd[`REG_ADDR_W-1:0];
            read_check("back_to_back", addr, 2);
        end

        $display("Test passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with frames still in progress", TIMEOUT_NS);
        $display("Test failed");
        $fatal(1, "Simulation timeout");
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
verilog/spi_target_pkg.sv
verilog/spi_byte_shifter.sv
verilog/spi_frame_counter.sv
verilog/spi_cmd_fsm.sv
verilog/reg_bank.sv
verilog/spi_target.sv
testbench/spi_target_assertions.sv
testbench/spi_target_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the SPI target simulation with Verilator and runs it.
# The exit status is the simulator's: nonzero on any failure.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f files.f \
    --top-module spi_target_tb \
    --Mdir obj_dir \
    -o spi_target_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/spi_target_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit "$sim_status"
fi

echo "Simulation finished with status 0"
exit 0
